// File: files.f
rtl/obj_pkg.sv
rtl/obj_frame_table.sv
rtl/obj_tile_match.sv
rtl/obj_scan.sv
rtl/obj_cmd_queue.sv
rtl/obj_top.sv
tb/obj_tb.sv

// File: Bender.yml
package:
  name: obj_scanner

sources:
  - rtl/obj_pkg.sv
  - rtl/obj_frame_table.sv
  - rtl/obj_tile_match.sv
  - rtl/obj_scan.sv
  - rtl/obj_cmd_queue.sv
  - rtl/obj_top.sv
  - target: test
    files:
      - tb/obj_tb.sv

// File: tb/obj_tb.sv
module obj_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import obj_pkg::*;

    localparam int TMO = 20000;

    logic                clk = 1'b0;
    logic                rst;
    logic                tbl_we;
    logic [TABLE_AW-1:0] tbl_waddr;
    obj_entry_t          tbl_wdata;
    logic                line_start;
    logic [8:0]          vrender;
    logic                flip;
    logic [9:0]          off_x;
    logic [9:0]          off_y;
    logic                scan_done;
    logic                out_valid;
    obj_cmd_t            out_cmd;
    logic                out_credit;

    // host copy of the table
    obj_entry_t  img [0:(1 << TABLE_AW)-1];
    obj_cmd_t    exp_q[$];
    obj_cmd_t    exp_a[$];
    obj_cmd_t    got_q[$];
    int          due_q[$];
    logic [31:0] lcg_state = 32'd38;
    logic        stingy = 1'b0;
    int          cycle = 0;
    int          idle = 0;
    int          outstanding = 0;

    obj_top DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_cmd(input string name, input obj_cmd_t exp, input obj_cmd_t act);
        if (act !== exp) begin
            fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            fail_now($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // expected command list for the current table image
    function automatic void build_model(input logic [8:0] vr, input logic fl,
                                        input logic [9:0] ox, input logic [9:0] oy);
        obj_entry_t e;
        obj_cmd_t   c;
        logic [8:0] vrf;
        logic [9:0] x;
        logic [9:0] y;
        logic [9:0] dy;
        logic [9:0] effx;
        logic [3:0] row;
        logic [3:0] subn;
        exp_q.delete();
        vrf = fl ? {vr[8], ~vr[7:0]} : vr;
        for (int a = 0; a < (1 << TABLE_AW); a++) begin
            e = img[a];
            if (e.y[15] || e.attr.raw.hi == END_BYTE) begin
                break;
            end
            x  = e.x[9:0] + X_BIAS - (e.attr.fields.abs_pos ? 10'd0 : ox);
            y  = e.y[9:0] + Y_BIAS - (e.attr.fields.abs_pos ? 10'd0 : oy);
            dy = {1'b0, vrf} - y;
            if (int'(dy) >= (int'(e.attr.fields.tile_m) + 1) * 16) begin
                continue;
            end
            row = e.attr.fields.vflip ? e.attr.fields.tile_m - dy[7:4] : dy[7:4];
            c.vsub    = e.attr.fields.vflip ? ~dy[3:0] : dy[3:0];
            c.prio    = e.x[15:13];
            c.bank    = e.y[14:13];
            c.attr_lo = e.attr.raw.lo;
            for (int n = 0; n <= e.attr.fields.tile_n; n++) begin
                subn = e.attr.fields.hflip ? e.attr.fields.tile_n - 4'(n) : 4'(n);
                effx = x + 10'(subn) * 10'd16;
                if (effx[9]) begin
                    continue;
                end
                c.hpos = effx[8:0];
                c.code = e.code + 16'(row) * 16'd16 + 16'(n);
                exp_q.push_back(c);
            end
        end
    endfunction

    // renderer model, collects commands and hands credits back
    always @(posedge clk) begin
        int outs;
        outs  = outstanding;
        cycle = cycle + 1;
        if (out_valid) begin
            got_q.push_back(out_cmd);
            outs++;
            if (outs > OUT_CREDITS) begin
                fail_now("renderer received more commands than it granted credits");
            end
            due_q.push_back(cycle + (stingy ? int'(lcg_next() >> 28) : 1));
        end
        idle <= out_valid ? 0 : idle + 1;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            outs--;
            out_credit <= 1'b1;
        end else begin
            out_credit <= 1'b0;
        end
        outstanding <= outs;
    end

    task automatic load_table(input int cnt);
        for (int a = 0; a < cnt; a++) begin
            @(posedge clk);
            tbl_we    <= 1'b1;
            tbl_waddr <= TABLE_AW'(a);
            tbl_wdata <= img[a];
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    task automatic start_line(input logic [8:0] vr, input logic fl,
                              input logic [9:0] ox, input logic [9:0] oy);
        @(posedge clk);
        line_start <= 1'b1;
        vrender    <= vr;
        flip       <= fl;
        off_x      <= ox;
        off_y      <= oy;
        @(posedge clk);
        line_start <= 1'b0;
    endtask

    // scan finished and the renderer link quiet
    task automatic wait_idle(input string name);
        int t;
        t = 0;
        while (!(scan_done === 1'b1 && idle >= 40)) begin
            @(posedge clk);
            t++;
            if (t > TMO) begin
                fail_now({name, ": scan never finished or commands kept coming"});
            end
        end
    endtask

    task automatic run_line(input string name, input logic [8:0] vr, input logic fl,
                            input logic [9:0] ox, input logic [9:0] oy);
        build_model(vr, fl, ox, oy);
        got_q.delete();
        start_line(vr, fl, ox, oy);
        @(posedge clk);
        check_count({name, " scan_done low"}, 0, int'(scan_done));
        wait_idle(name);
        check_count({name, " command count"}, exp_q.size(), got_q.size());
        foreach (exp_q[i]) begin
            check_cmd(name, exp_q[i], got_q[i]);
        end
    endtask

    task automatic test_reset();
        check_count("reset scan_done", 1, int'(scan_done));
        check_count("reset out_valid", 0, int'(out_valid));
        img[0] = {16'h0000, 16'h8000, 32'h0};
        load_table(1);
        run_line("empty table", 9'h020, 1'b0, 10'h000, 10'h000);
    endtask

    task automatic test_single();
        // prio 5 bank 2 with offsets, then abs_pos, then two misses
        img[0] = {16'ha100, 16'h4080, 16'h1234, 16'h0003};
        img[1] = {16'h2020, 16'h2078, 16'h0055, 16'h0091};
        img[2] = {16'h0100, 16'h0200, 16'h0777, 16'h0000};
        img[3] = {16'h0100, 16'h0098, 16'h0888, 16'h0000};
        img[4] = {16'h0000, 16'h8000, 32'h0};
        load_table(5);
        run_line("single tile", 9'h08c, 1'b0, 10'h030, 10'h008);
        check_count("single tile hits", 2, exp_q.size());
    endtask

    task automatic test_multi();
        // 4x3 plain, 4x3 flipped, then two objects running off the right edge
        img[0] = {16'h0100, 16'h00db, 16'h0400, 16'h2301};
        img[1] = {16'h0100, 16'h00db, 16'h0500, 16'h2362};
        img[2] = {16'h01f0, 16'h00f8, 16'h0600, 16'h0300};
        img[3] = {16'h03f0, 16'h00f8, 16'h0700, 16'h0320};
        img[4] = {16'h0100, 16'h00f8, 16'h0900, 16'hff00};
        load_table(5);
        run_line("multi tile", 9'h100, 1'b0, 10'h040, 10'h010);
        check_count("multi tile hits", 12, exp_q.size());
    endtask

    task automatic test_end();
        for (int a = 0; a < 10; a++) begin
            img[a] = {16'(a * 16), 16'h0040, 16'(a), 16'h0004};
        end
        img[5].y[15] = 1'b1;
        load_table(10);
        run_line("end flag", 9'h040, 1'b0, 10'h040, 10'h010);
        check_count("end flag hits", 5, exp_q.size());
        img[5].y[15]       = 1'b0;
        img[3].attr.raw.hi = END_BYTE;
        load_table(10);
        run_line("end byte", 9'h040, 1'b0, 10'h040, 10'h010);
        check_count("end byte hits", 3, exp_q.size());
        // no marker anywhere, the walk stops after entry 1023
        for (int a = 0; a < (1 << TABLE_AW); a++) begin
            img[a] = {16'(a % 512), 16'h0040, 16'(a), 16'h0000};
        end
        load_table(1 << TABLE_AW);
        run_line("full table", 9'h040, 1'b0, 10'h040, 10'h010);
        check_count("full table hits", 1 << TABLE_AW, exp_q.size());
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        for (int a = 0; a < 40; a++) begin
            r = lcg_next();
            img[a] = {r[2:0], 4'h0, r[12:4],
                      1'b0, r[14:13], 3'h0, 10'h0c0 - {6'h0, r[18:15]},
                      r[31:16],
                      6'h00, r[20:19], 1'b0, r[22:21], r[27:23]};
        end
        img[40] = {16'h0000, 16'h8000, 32'h0};
        load_table(41);
        stingy = 1'b1;
        run_line("dense stingy", 9'h0c0, 1'b0, 10'h040, 10'h010);
        stingy = 1'b0;
    endtask

    task automatic test_restart();
        int k;
        build_model(9'h0c0, 1'b0, 10'h040, 10'h010);
        exp_a = exp_q;
        got_q.delete();
        start_line(9'h0c0, 1'b0, 10'h040, 10'h010);
        repeat (20) @(posedge clk);
        // flipped line lands on the same rows, shifted left by 8
        build_model(9'h03f, 1'b1, 10'h048, 10'h010);
        start_line(9'h03f, 1'b1, 10'h048, 10'h010);
        wait_idle("restart");
        k = got_q.size() - exp_q.size();
        if (k < 0 || k > exp_a.size()) begin
            fail_now("restart: first line left a wrong number of commands in front");
        end
        for (int i = 0; i < k; i++) begin
            check_cmd("restart first line", exp_a[i], got_q[i]);
        end
        foreach (exp_q[i]) begin
            check_cmd("restart second line", exp_q[i], got_q[k + i]);
        end
    endtask

    initial begin
        rst        = 1'b1;
        tbl_we     = 1'b0;
        tbl_waddr  = '0;
        tbl_wdata  = '0;
        line_start = 1'b0;
        vrender    = '0;
        flip       = 1'b0;
        off_x      = '0;
        off_y      = '0;
        out_credit = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset();
        test_single();
        test_multi();
        test_end();
        test_backpressure();
        test_restart();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: rtl/obj_top.sv
module obj_top (
    input  logic                         clk,
    input  logic                         rst,

    // host table access
    input  logic                         tbl_we,
    input  logic [obj_pkg::TABLE_AW-1:0] tbl_waddr,
    input  obj_pkg::obj_entry_t          tbl_wdata,

    // line control
    input  logic                         line_start,
    input  logic [8:0]                   vrender,
    input  logic                         flip,
    input  logic [9:0]                   off_x,
    input  logic [9:0]                   off_y,
    output logic                         scan_done,

    // renderer link
    output logic                         out_valid,
    output obj_pkg::obj_cmd_t            out_cmd,
    input  logic                         out_credit
);
    import obj_pkg::*;

    logic [TABLE_AW-1:0] rd_addr;
    logic                rd_en;
    obj_entry_t          rd_data;
    logic                cmd_valid;
    obj_cmd_t            cmd;
    logic                cmd_credit;

    obj_frame_table u_table (
        .clk     (clk),
        .we      (tbl_we),
        .waddr   (tbl_waddr),
        .wdata   (tbl_wdata),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .flip       (flip),
        .off_x      (off_x),
        .off_y      (off_y),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .cmd_credit (cmd_credit),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .scan_done  (scan_done)
    );

    obj_cmd_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (cmd_valid),
        .in_cmd     (cmd),
        .in_credit  (cmd_credit),
        .out_valid  (out_valid),
        .out_cmd    (out_cmd),
        .out_credit (out_credit)
    );

endmodule

// File: rtl/obj_cmd_queue.sv
module obj_cmd_queue (
    input  logic              clk,
    input  logic              rst,

    // scanner side
    input  logic              in_valid,
    input  obj_pkg::obj_cmd_t in_cmd,
    output logic              in_credit,

    // renderer side
    output logic              out_valid,
    output obj_pkg::obj_cmd_t out_cmd,
    input  logic              out_credit
);
    import obj_pkg::*;

    obj_cmd_t           mem [CMD_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CRED_W-1:0]  count;
    logic [OCRED_W-1:0] out_cred;
    logic               pop;

    // pop as soon as there is data and a renderer credit
    assign pop = (count != '0) && (out_cred != '0);

    assign out_valid = pop;
    assign out_cmd   = mem[rd_ptr];

    // each freed slot goes back to the scanner
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_cmd;
        end
    end

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CRED_W'(in_valid) - CRED_W'(pop);
        end
    end

    // renderer credits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_cred <= OCRED_W'(OUT_CREDITS);
        end else begin
            out_cred <= out_cred - OCRED_W'(pop) + OCRED_W'(out_credit);
        end
    end

endmodule

// File: rtl/obj_scan.sv
module obj_scan (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         line_start,
    input  logic [8:0]                   vrender,
    input  logic                         flip,
    input  logic [9:0]                   off_x,
    input  logic [9:0]                   off_y,

    // frame table
    output logic [obj_pkg::TABLE_AW-1:0] rd_addr,
    output logic                         rd_en,
    input  obj_pkg::obj_entry_t          rd_data,

    // command queue, credit based
    input  logic                         cmd_credit,
    output logic                         cmd_valid,
    output obj_pkg::obj_cmd_t            cmd,

    output logic                         scan_done
);
    import obj_pkg::*;

    logic [8:0]        vrenderf;
    logic              fetching;
    logic              rd_valid;
    logic              end_hit;
    logic [9:0]        s2_x;
    logic [9:0]        s2_y;

    logic              s3_valid;
    logic [9:0]        st3_x;
    logic [9:0]        st3_y;
    logic [15:0]       st3_code;
    obj_attr_u         st3_attr;
    logic [2:0]        st3_prio;
    logic [1:0]        st3_bank;

    logic              s4_valid;
    logic [9:0]        st4_x;
    obj_attr_u         st4_attr;
    logic [2:0]        st4_prio;
    logic [1:0]        st4_bank;
    logic              inzone;
    logic [3:0]        st4_vsub;
    logic [15:0]       code_mn;

    logic [3:0]        n;
    logic [3:0]        subn;
    logic [9:0]        effx;
    logic              s4_act;
    logic              s4_last;
    logic              s4_done;
    logic              tile_skip;
    logic              tile_go;
    logic              tile_emit;
    logic              stall;
    logic              pipe_empty;
    logic [CRED_W-1:0] credits;
    logic              credit_nz;

    obj_tile_match u_tile_match (
        .clk      (clk),
        .rst      (rst),
        .en       (~stall),
        .obj_y    (st3_y),
        .vrenderf (vrenderf),
        .attr     (st3_attr),
        .code     (st3_code),
        .inzone   (inzone),
        .vsub     (st4_vsub),
        .code_mn  (code_mn)
    );

    // stage II, end markers and screen positions
    assign end_hit = rd_valid && (rd_data.y[15] || (rd_data.attr.raw.hi == END_BYTE));
    assign s2_x = rd_data.x[9:0] + X_BIAS - (rd_data.attr.fields.abs_pos ? 10'd0 : off_x);
    assign s2_y = rd_data.y[9:0] + Y_BIAS - (rd_data.attr.fields.abs_pos ? 10'd0 : off_y);

    // stage IV, horizontal tile expansion
    assign s4_act    = s4_valid && inzone;
    assign subn      = st4_attr.fields.hflip ? (st4_attr.fields.tile_n - n) : n;
    assign effx      = st4_x + {2'b00, subn, 4'd0};
    assign tile_skip = effx[9];
    assign credit_nz = (credits != '0);
    assign tile_go   = s4_act && (tile_skip || credit_nz);
    assign tile_emit = tile_go && !tile_skip;
    assign s4_last   = (n == st4_attr.fields.tile_n);

    // upstream moves only when stage IV frees up this cycle
    assign s4_done = !s4_act || (tile_go && s4_last);
    assign stall   = !s4_done;
    assign rd_en   = fetching && !stall;

    assign pipe_empty = !fetching && !rd_valid && !s3_valid && !s4_act;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vrenderf  <= '0;
            rd_addr   <= '0;
            fetching  <= 1'b0;
            rd_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            s4_valid  <= 1'b0;
            n         <= '0;
            cmd_valid <= 1'b0;
            scan_done <= 1'b1;
        end else begin
            cmd_valid <= tile_emit;
            if (tile_go) begin
                n <= s4_last ? 4'd0 : n + 4'd1;
            end
            if (!stall) begin
                // stage I
                // entry 1023 is still read and drawn, then fetching stops
                if (fetching) begin
                    rd_addr <= rd_addr + 1'b1;
                    if (&rd_addr) begin
                        fetching <= 1'b0;
                    end
                end
                // a read issued alongside an end marker is dropped
                rd_valid <= fetching && !end_hit;
                if (end_hit) begin
                    fetching <= 1'b0;
                end
                s3_valid <= rd_valid && !end_hit;
                s4_valid <= s3_valid;
            end
            if (pipe_empty) begin
                scan_done <= 1'b1;
            end
            // restart wins over everything above
            if (line_start) begin
                vrenderf  <= vrender ^ {1'b0, {8{flip}}};
                rd_addr   <= '0;
                fetching  <= 1'b1;
                rd_valid  <= 1'b0;
                s3_valid  <= 1'b0;
                s4_valid  <= 1'b0;
                n         <= '0;
                scan_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            st3_x    <= s2_x;
            st3_y    <= s2_y;
            st3_code <= rd_data.code;
            st3_attr <= rd_data.attr;
            st3_prio <= rd_data.x[15:13];
            st3_bank <= rd_data.y[14:13];
            st4_x    <= st3_x;
            st4_attr <= st3_attr;
            st4_prio <= st3_prio;
            st4_bank <= st3_bank;
        end
        if (tile_emit) begin
            cmd.code    <= code_mn + {12'd0, n};
            cmd.vsub    <= st4_vsub;
            cmd.hpos    <= effx[8:0];
            cmd.prio    <= st4_prio;
            cmd.bank    <= st4_bank;
            cmd.attr_lo <= st4_attr.raw.lo;
        end
    end

    // one credit per queue slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CRED_W'(CMD_DEPTH);
        end else begin
            credits <= credits - CRED_W'(tile_emit) + CRED_W'(cmd_credit);
        end
    end

endmodule

// File: rtl/obj_tile_match.sv
module obj_tile_match (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,

    input  logic [9:0]         obj_y,
    input  logic [8:0]         vrenderf,
    input  obj_pkg::obj_attr_u attr,
    input  logic [15:0]        code,

    output logic               inzone,
    output logic [3:0]         vsub,
    output logic [15:0]        code_mn
);

    logic [9:0] dy;
    logic       hit;
    logic [3:0] row;
    logic [3:0] row_sel;
    logic [3:0] sub_sel;

    // distance below the object top, wraps at 1024
    assign dy = {1'b0, vrenderf} - obj_y;

    // dy < (tile_m+1)*16 needs dy[9:8] clear and the row within tile_m
    assign hit = (dy[9:8] == 2'b00) && (dy[7:4] <= attr.fields.tile_m);

    assign row = dy[7:4];

    // vertical flip mirrors both the tile row and the pixel row
    assign row_sel = attr.fields.vflip ? (attr.fields.tile_m - row) : row;
    assign sub_sel = attr.fields.vflip ? ~dy[3:0] : dy[3:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
        end else if (en) begin
            inzone <= hit;
        end
    end

    // tile rows are 16 codes apart
    always_ff @(posedge clk) begin
        if (en) begin
            vsub    <= sub_sel;
            code_mn <= code + {8'd0, row_sel, 4'd0};
        end
    end

endmodule

// File: rtl/obj_frame_table.sv
module obj_frame_table (
    input  logic                         clk,

    // host write port
    input  logic                         we,
    input  logic [obj_pkg::TABLE_AW-1:0] waddr,
    input  obj_pkg::obj_entry_t          wdata,

    // scanner read port
    input  logic                         rd_en,
    input  logic [obj_pkg::TABLE_AW-1:0] rd_addr,
    output obj_pkg::obj_entry_t          rd_data
);
    import obj_pkg::*;

    obj_entry_t mem [0:(1 << TABLE_AW)-1];

    // one entry per cycle from the host
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read
    // output keeps the last entry while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: rtl/obj_pkg.sv
package obj_pkg;

    localparam int TABLE_AW    = 10;
    localparam int CMD_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;

    // counter and pointer widths
    localparam int CRED_W  = $clog2(CMD_DEPTH + 1);
    localparam int OCRED_W = $clog2(OUT_CREDITS + 1);
    localparam int PTR_W   = $clog2(CMD_DEPTH);

    // fixed screen offsets applied to object positions
    localparam logic [9:0] X_BIAS = 10'h040;
    localparam logic [9:0] Y_BIAS = 10'h010;

    // attribute high byte that terminates the table
    localparam logic [7:0] END_BYTE = 8'hff;

    typedef struct packed {
        logic [3:0] tile_m;
        logic [3:0] tile_n;
        logic       abs_pos;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_fields_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } obj_attr_raw_t;

    // byte view for the end test, field view for drawing
    typedef union packed {
        obj_attr_fields_t fields;
        obj_attr_raw_t    raw;
    } obj_attr_u;

    // x: prio in 15:13, position in 9:0
    // y: end flag in 15, bank in 14:13, position in 9:0
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        obj_attr_u   attr;
    } obj_entry_t;

    typedef struct packed {
        logic [15:0] code;
        logic [3:0]  vsub;
        logic [8:0]  hpos;
        logic [2:0]  prio;
        logic [1:0]  bank;
        logic [7:0]  attr_lo;
    } obj_cmd_t;

endpackage
